// ==== src/pd_pkg.sv ====
package pd_pkg;

  ////////////////////
  // Widths and sizes
  ////////////////////

  // Data and address width
  localparam int XLEN = 32;

  // Return stack entries
  localparam int RSB_DEPTH = 4;

  // Return stack fill count, 0 up to RSB_DEPTH
  localparam int RSB_CNT_W = $clog2(RSB_DEPTH + 1);

  // CSR address field
  localparam int CSR_ADDR_W = 12;

  // Fixed 32-bit instructions
  localparam logic [XLEN-1:0] INSN_BYTES = 4;

  // Word alignment, low two bits cleared
  localparam logic [XLEN-1:0] ADDR_MASK = {{(XLEN-2){1'b1}}, 2'b00};

  ////////////////////
  // Basic types
  ////////////////////

  typedef logic [4:0] reg_addr_t;
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;

  // Bit 1 set means predicted taken
  typedef logic [1:0] bp_tag_t;

  // Major opcodes used by the pre-decoder
  localparam opcode_t OPC_JAL    = 7'b110_1111;
  localparam opcode_t OPC_JALR   = 7'b110_0111;
  localparam opcode_t OPC_BRANCH = 7'b110_0011;
  localparam opcode_t OPC_SYSTEM = 7'b111_0011;

  // SYSTEM funct3 values of the Zicsr group
  localparam funct3_t F3_CSRRW  = 3'b001;
  localparam funct3_t F3_CSRRS  = 3'b010;
  localparam funct3_t F3_CSRRC  = 3'b011;
  localparam funct3_t F3_CSRRWI = 3'b101;
  localparam funct3_t F3_CSRRSI = 3'b110;
  localparam funct3_t F3_CSRRCI = 3'b111;

  // Link registers, ra and the alternate link t0
  localparam reg_addr_t REG_RA = 5'd1;
  localparam reg_addr_t REG_T0 = 5'd5;

  // Tag values of the static rule
  localparam bp_tag_t TAG_NONE = 2'b00;
  localparam bp_tag_t TAG_JAL  = 2'b10;

  ////////////////////
  // Pipeline payloads
  ////////////////////

  // Instruction word plus bubble marker
  typedef struct packed {
    logic [XLEN-1:0] instr;
    logic            bubble;
  } insn_t;

  // Fetch exceptions, any is the OR of the others
  typedef struct packed {
    logic illegal;
    logic misaligned;
    logic fault;
    logic any;
  } exc_t;

  ////////////////////
  // Reset values
  ////////////////////

  localparam logic [XLEN-1:0] PC_INIT = 32'h0000_0200;

  // ADDI x0,x0,0
  localparam logic [XLEN-1:0] INSTR_NOP = 32'h0000_0013;

  localparam exc_t EXC_NONE = '0;

endpackage

// ==== src/pd_decode_if.sv ====
`timescale 1ns/1ps

interface pd_decode_if;

  // Register file indices
  pd_pkg::reg_addr_t rs1;
  pd_pkg::reg_addr_t rs2;
  pd_pkg::reg_addr_t rd;

  pd_pkg::opcode_t opcode;

  // Sign-extended jump and branch offsets
  logic [pd_pkg::XLEN-1:0] imm_j;
  logic [pd_pkg::XLEN-1:0] imm_b;

  logic [pd_pkg::CSR_ADDR_W-1:0] csr_addr;
  logic                          csr_write;

  // Return stack requests from the link rule
  logic rsb_push;
  logic rsb_pop;

  modport producer (
    output rs1, rs2, rd, opcode, imm_j, imm_b, csr_addr, csr_write, rsb_push, rsb_pop
  );

  modport consumer (
    input rs1, rs2, rd, opcode, imm_j, imm_b, csr_addr, csr_write, rsb_push, rsb_pop
  );

endinterface

// ==== src/pd_insn_decode.sv ====
`timescale 1ns/1ps

module pd_insn_decode (
  input  pd_pkg::insn_t insn_i,
  pd_decode_if.producer dec
);

  logic [pd_pkg::XLEN-1:0] instr;
  pd_pkg::reg_addr_t       rs1;
  pd_pkg::reg_addr_t       rd;
  pd_pkg::opcode_t         opcode;
  pd_pkg::funct3_t         funct3;
  logic                    link_rs1;
  logic                    link_rd;
  logic                    csr_write;

  assign instr  = insn_i.instr;
  assign rs1    = instr[19:15];
  assign rd     = instr[11:7];
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];

  ////////////////////
  // Plain fields
  ////////////////////

  assign dec.rs1      = rs1;
  assign dec.rs2      = instr[24:20];
  assign dec.rd       = rd;
  assign dec.opcode   = opcode;
  assign dec.csr_addr = instr[31:20];

  // J-type offset, bit 0 always zero
  assign dec.imm_j = {{(pd_pkg::XLEN-20){instr[31]}}, instr[19:12], instr[20],
                      instr[30:21], 1'b0};

  // B-type offset
  assign dec.imm_b = {{(pd_pkg::XLEN-12){instr[31]}}, instr[7], instr[30:25],
                      instr[11:8], 1'b0};

  ////////////////////
  // CSR write detect
  ////////////////////

  // Set and clear forms only write with a nonzero source
  // Immediate forms keep their zimm in the rs1 field
  always_comb begin
    csr_write = 1'b0;
    if (opcode == pd_pkg::OPC_SYSTEM) begin
      case (funct3)
        pd_pkg::F3_CSRRW,
        pd_pkg::F3_CSRRWI: csr_write = 1'b1;
        pd_pkg::F3_CSRRS,
        pd_pkg::F3_CSRRC,
        pd_pkg::F3_CSRRSI,
        pd_pkg::F3_CSRRCI: csr_write = |rs1;
        default:           csr_write = 1'b0;
      endcase
    end
  end

  assign dec.csr_write = csr_write;

  ////////////////////
  // Link rule
  ////////////////////

  // x1 or x5 count as link registers
  assign link_rs1 = (rs1 == pd_pkg::REG_RA) || (rs1 == pd_pkg::REG_T0);
  assign link_rd  = (rd  == pd_pkg::REG_RA) || (rd  == pd_pkg::REG_T0);

  // Link in rd always pushes
  assign dec.rsb_push = link_rd;

  // Pop on a link source, unless it is the same link as rd
  assign dec.rsb_pop = link_rs1 & (~link_rd | (rs1 != rd));

endmodule

// ==== src/return_stack.sv ====
`timescale 1ns/1ps

module return_stack (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    ena_i,
  input  logic                    push_i,
  input  logic                    pop_i,
  input  logic [pd_pkg::XLEN-1:0] d_i,
  output logic [pd_pkg::XLEN-1:0] q_o,
  output logic                    empty_o
);

  // Entry 0 is the top, deeper entries are older
  logic [pd_pkg::XLEN-1:0]      stack_q [pd_pkg::RSB_DEPTH];
  logic [pd_pkg::RSB_CNT_W-1:0] cnt_q;

  assign empty_o = (cnt_q == '0);
  assign q_o     = empty_o ? '0 : stack_q[0];

  // Entry storage
  always_ff @(posedge clk_i) begin
    if (ena_i) begin
      if (push_i && pop_i) begin
        // Return then call, top is overwritten
        stack_q[0] <= d_i;
      end else if (push_i) begin
        // Shift down, oldest entry falls off when full
        stack_q[0] <= d_i;
        for (int i = 1; i < pd_pkg::RSB_DEPTH; i++) begin
          stack_q[i] <= stack_q[i-1];
        end
      end else if (pop_i && !empty_o) begin
        for (int i = 0; i < pd_pkg::RSB_DEPTH - 1; i++) begin
          stack_q[i] <= stack_q[i+1];
        end
      end
    end
  end

  // Fill count, saturates at the depth
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (ena_i) begin
      if (push_i && pop_i) begin
        if (empty_o) cnt_q <= 1;
      end else if (push_i) begin
        if (cnt_q != pd_pkg::RSB_DEPTH) cnt_q <= cnt_q + 1'b1;
      end else if (pop_i && !empty_o) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Count stays within the array
  a_cnt_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cnt_q <= pd_pkg::RSB_DEPTH);

endmodule

// ==== src/pd_branch_predict.sv ====
`timescale 1ns/1ps

module pd_branch_predict (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  pd_pkg::insn_t           insn_i,
  input  logic [pd_pkg::XLEN-1:0] pc_i,
  input  logic                    id_stall_i,
  pd_decode_if.consumer           dec,
  input  logic [pd_pkg::XLEN-1:0] rsb_top_i,
  output logic                    rsb_push_o,
  output logic                    rsb_pop_o,
  output logic                    taken_o,
  output pd_pkg::bp_tag_t         tag_o,
  output logic [pd_pkg::XLEN-1:0] nxt_pc_o,
  output logic                    latch_nxt_pc_o
);

  // Taken decision held off by the decode stall last cycle
  logic stalled_branch_q;

  ////////////////////
  // Static prediction
  ////////////////////

  always_comb begin
    taken_o    = 1'b0;
    tag_o      = pd_pkg::TAG_NONE;
    rsb_push_o = 1'b0;
    rsb_pop_o  = 1'b0;
    nxt_pc_o   = pc_i;
    // Bubbles never predict
    if (!insn_i.bubble) begin
      case (dec.opcode)
        pd_pkg::OPC_JAL: begin
          taken_o    = 1'b1;
          tag_o      = pd_pkg::TAG_JAL;
          rsb_push_o = dec.rsb_push;
          rsb_pop_o  = dec.rsb_pop;
          nxt_pc_o   = pc_i + dec.imm_j;
        end
        pd_pkg::OPC_JALR: begin
          // Only returns are predictable, target from the stack
          taken_o    = dec.rsb_pop;
          rsb_push_o = dec.rsb_push;
          rsb_pop_o  = dec.rsb_pop;
          nxt_pc_o   = rsb_top_i;
        end
        pd_pkg::OPC_BRANCH: begin
          // Backward taken, forward not taken
          taken_o  = dec.imm_b[pd_pkg::XLEN-1];
          tag_o    = {dec.imm_b[pd_pkg::XLEN-1], 1'b0};
          nxt_pc_o = pc_i + dec.imm_b;
        end
        default: ;
      endcase
    end
  end

  ////////////////////
  // Latch strobe
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) stalled_branch_q <= 1'b0;
    else         stalled_branch_q <= taken_o & id_stall_i;
  end

  // One strobe per prediction under back-pressure
  assign latch_nxt_pc_o = taken_o & ~stalled_branch_q;

  a_no_latch_on_bubble: assert property (@(posedge clk_i) disable iff (!rst_ni)
    latch_nxt_pc_o |-> !insn_i.bubble);

endmodule

// ==== src/pd_stage_regs.sv ====
`timescale 1ns/1ps

module pd_stage_regs (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    id_stall_i,
  input  logic                    bu_flush_i,
  input  logic                    st_flush_i,
  input  logic [pd_pkg::XLEN-1:0] bu_nxt_pc_i,
  input  logic [pd_pkg::XLEN-1:0] st_nxt_pc_i,
  input  logic                    later_exc_i,
  input  pd_pkg::insn_t           if_insn_i,
  input  logic [pd_pkg::XLEN-1:0] if_pc_i,
  input  pd_pkg::exc_t            if_exc_i,
  input  pd_pkg::bp_tag_t         tag_i,
  input  logic [pd_pkg::XLEN-1:0] rsb_top_i,
  pd_decode_if.consumer           dec,
  output logic                    pd_stall_o,
  output pd_pkg::insn_t           pd_insn_o,
  output logic [pd_pkg::XLEN-1:0] pd_pc_o,
  output pd_pkg::exc_t            pd_exc_o,
  output pd_pkg::bp_tag_t         pd_tag_o,
  output logic [pd_pkg::XLEN-1:0] pd_rsb_pc_o
);

  logic                    flush;
  logic                    csr_start;
  logic [1:0]              csr_seq_q;
  logic [pd_pkg::XLEN-1:0] instr_q;
  logic                    bubble_q;

  assign flush = bu_flush_i | st_flush_i;

  ////////////////////
  // CSR write stall
  ////////////////////

  // Two cycles so the CSR is written before a following read
  assign csr_start = dec.csr_write & ~if_insn_i.bubble;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      csr_seq_q <= 2'b00;
    end else if (csr_seq_q[1]) begin
      // Second stall cycle done
      csr_seq_q <= 2'b00;
    end else if (!id_stall_i) begin
      csr_seq_q[0] <= csr_start | csr_seq_q[0];
      csr_seq_q[1] <= csr_seq_q[0];
    end
  end

  assign pd_stall_o = id_stall_i | csr_seq_q[0];

  ////////////////////
  // Stage registers
  ////////////////////

  // PC, state flush wins over branch flush
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni)          pd_pc_o <= pd_pkg::PC_INIT & pd_pkg::ADDR_MASK;
    else if (st_flush_i)  pd_pc_o <= st_nxt_pc_i & pd_pkg::ADDR_MASK;
    else if (bu_flush_i)  pd_pc_o <= bu_nxt_pc_i & pd_pkg::ADDR_MASK;
    else if (!pd_stall_o) pd_pc_o <= if_pc_i & pd_pkg::ADDR_MASK;
  end

  // Instruction word follows decode back-pressure only
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni)         instr_q <= pd_pkg::INSTR_NOP;
    else if (!id_stall_i) instr_q <= if_insn_i.instr;
  end

  // Bubble insertion
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni)                          bubble_q <= 1'b1;
    else if (flush || later_exc_i)        bubble_q <= 1'b1;
    else if (!id_stall_i && |csr_seq_q)   bubble_q <= 1'b1;
    else if (!id_stall_i)                 bubble_q <= if_insn_i.bubble;
  end

  assign pd_insn_o = '{instr: instr_q, bubble: bubble_q};

  // Exceptions, dropped on a flush or stall
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni)                  pd_exc_o <= pd_pkg::EXC_NONE;
    else if (flush || pd_stall_o) pd_exc_o <= pd_pkg::EXC_NONE;
    else                          pd_exc_o <= if_exc_i;
  end

  // Prediction tag
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni)          pd_tag_o <= pd_pkg::TAG_NONE;
    else if (!pd_stall_o) pd_tag_o <= tag_i;
  end

  // Return stack top seen by this instruction
  always_ff @(posedge clk_i) begin
    if (!pd_stall_o) pd_rsb_pc_o <= rsb_top_i;
  end

  a_pc_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (pd_pc_o & ~pd_pkg::ADDR_MASK) == '0);

endmodule

// ==== src/pre_decode_top.sv ====
`timescale 1ns/1ps

module pre_decode_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Fetch side
  input  pd_pkg::insn_t                 if_insn_i,
  input  logic [pd_pkg::XLEN-1:0]       if_pc_i,
  input  pd_pkg::exc_t                  if_exc_i,
  // Decode and later stages
  input  logic                          id_stall_i,
  input  logic                          later_exc_i,
  input  logic                          bu_flush_i,
  input  logic                          st_flush_i,
  input  logic [pd_pkg::XLEN-1:0]       bu_nxt_pc_i,
  input  logic [pd_pkg::XLEN-1:0]       st_nxt_pc_i,
  // Registered stage outputs
  output pd_pkg::insn_t                 pd_insn_o,
  output logic [pd_pkg::XLEN-1:0]       pd_pc_o,
  output pd_pkg::exc_t                  pd_exc_o,
  output pd_pkg::bp_tag_t               pd_tag_o,
  output logic [pd_pkg::XLEN-1:0]       pd_rsb_pc_o,
  // Early register file and CSR addresses
  output pd_pkg::reg_addr_t             pd_rs1_o,
  output pd_pkg::reg_addr_t             pd_rs2_o,
  output logic [pd_pkg::CSR_ADDR_W-1:0] pd_csr_addr_o,
  // Prediction and pipeline control
  output logic [pd_pkg::XLEN-1:0]       pd_nxt_pc_o,
  output logic                          pd_latch_nxt_pc_o,
  output logic                          pd_stall_o,
  output logic                          pd_flush_o
);

  logic [pd_pkg::XLEN-1:0] rsb_ret_pc;
  logic [pd_pkg::XLEN-1:0] rsb_top;
  logic                    rsb_push;
  logic                    rsb_pop;
  logic                    rsb_empty;
  logic                    bp_taken;
  pd_pkg::bp_tag_t         bp_tag;

  pd_decode_if dec_if ();

  assign pd_flush_o    = bu_flush_i | st_flush_i;
  assign pd_rs1_o      = dec_if.rs1;
  assign pd_rs2_o      = dec_if.rs2;
  assign pd_csr_addr_o = dec_if.csr_addr;

  // Link address of a call
  assign rsb_ret_pc = if_pc_i + pd_pkg::INSN_BYTES;

  pd_insn_decode pd_insn_decode_inst (.insn_i(if_insn_i), .dec(dec_if.producer));

  return_stack return_stack_inst (
    .clk_i, .rst_ni, .ena_i(!pd_stall_o), .push_i(rsb_push), .pop_i(rsb_pop),
    .d_i(rsb_ret_pc), .q_o(rsb_top), .empty_o(rsb_empty)
  );

  pd_branch_predict pd_branch_predict_inst (
    .clk_i, .rst_ni, .insn_i(if_insn_i), .pc_i(if_pc_i), .id_stall_i,
    .dec(dec_if.consumer), .rsb_top_i(rsb_top), .rsb_push_o(rsb_push),
    .rsb_pop_o(rsb_pop), .taken_o(bp_taken), .tag_o(bp_tag),
    .nxt_pc_o(pd_nxt_pc_o), .latch_nxt_pc_o(pd_latch_nxt_pc_o)
  );

  pd_stage_regs pd_stage_regs_inst (
    .clk_i, .rst_ni, .id_stall_i, .bu_flush_i, .st_flush_i, .bu_nxt_pc_i, .st_nxt_pc_i,
    .later_exc_i, .if_insn_i, .if_pc_i, .if_exc_i, .tag_i(bp_tag), .rsb_top_i(rsb_top),
    .dec(dec_if.consumer), .pd_stall_o, .pd_insn_o, .pd_pc_o, .pd_exc_o, .pd_tag_o,
    .pd_rsb_pc_o
  );

  // A predicted return needs a filled stack
  a_ret_has_target: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (bp_taken && dec_if.opcode == pd_pkg::OPC_JALR) |-> !rsb_empty);

endmodule

// ==== testbench/pd_ref_model.svh ====
`ifndef PD_REF_MODEL_SVH
`define PD_REF_MODEL_SVH

// Stage registers as seen by decode
logic [pd_pkg::XLEN-1:0] m_pc;
pd_pkg::insn_t           m_insn;
pd_pkg::exc_t            m_exc;
pd_pkg::bp_tag_t         m_tag;
logic [pd_pkg::XLEN-1:0] m_rsb_pc;
logic                    m_rsb_pc_ok;
logic [1:0]              m_csr_seq;
logic                    m_stalled_br;
// Front of the queue is the top of the return stack
logic [pd_pkg::XLEN-1:0] m_stack [$];

// Same-cycle expectations from the fetch inputs
logic                    m_taken;
logic                    m_push;
logic                    m_pop;
logic                    m_stall;
pd_pkg::bp_tag_t         m_tag_nxt;
logic [pd_pkg::XLEN-1:0] m_nxt_pc;

function automatic void model_reset();
  m_pc = pd_pkg::PC_INIT;
  m_insn = '{instr: pd_pkg::INSTR_NOP, bubble: 1'b1};
  m_exc = '0;
  m_tag = 2'b00;
  m_rsb_pc_ok = 1'b0;
  m_csr_seq = 2'b00;
  m_stalled_br = 1'b0;
  m_stack.delete();
endfunction

// ra or t0
function automatic logic is_link(pd_pkg::reg_addr_t r);
  return (r == 5'd1) || (r == 5'd5);
endfunction

function automatic logic [pd_pkg::XLEN-1:0] stack_top();
  return (m_stack.size() == 0) ? '0 : m_stack[0];
endfunction

// RW forms always write, set and clear forms need a nonzero source
function automatic logic writes_csr(logic [31:0] w);
  if (w[6:0] != pd_pkg::OPC_SYSTEM) return 1'b0;
  case (w[14:12])
    3'b001, 3'b101: return 1'b1;
    3'b010, 3'b011, 3'b110, 3'b111: return |w[19:15];
    default: return 1'b0;
  endcase
endfunction

////////////////////
// Prediction
////////////////////

function automatic void model_predict();
  logic [31:0] w;
  logic [31:0] imm;
  logic        jump;
  w = if_insn_i.instr;
  jump = !if_insn_i.bubble && (w[6:0] == pd_pkg::OPC_JAL || w[6:0] == pd_pkg::OPC_JALR);
  m_taken = 1'b0;
  m_tag_nxt = 2'b00;
  m_nxt_pc = if_pc_i;
  m_stall = id_stall_i | m_csr_seq[0];
  // Link rule, same link in rd and rs1 only pushes
  m_push = jump && is_link(w[11:7]);
  m_pop = jump && is_link(w[19:15]) && !(is_link(w[11:7]) && w[19:15] == w[11:7]);
  if (!if_insn_i.bubble && w[6:0] == pd_pkg::OPC_JAL) begin
    imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    m_taken = 1'b1;
    m_tag_nxt = 2'b10;
    m_nxt_pc = if_pc_i + imm;
  end else if (!if_insn_i.bubble && w[6:0] == pd_pkg::OPC_BRANCH) begin
    // Backward taken
    imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    m_taken = imm[31];
    m_tag_nxt = {imm[31], 1'b0};
    m_nxt_pc = if_pc_i + imm;
  end else if (!if_insn_i.bubble && w[6:0] == pd_pkg::OPC_JALR) begin
    m_taken = m_pop;
    m_nxt_pc = stack_top();
  end
endfunction

////////////////////
// Clock edge
////////////////////

function automatic void model_advance();
  logic                    flush;
  logic [pd_pkg::XLEN-1:0] ret_pc;
  flush = bu_flush_i | st_flush_i;
  ret_pc = if_pc_i + 32'd4;
  if (st_flush_i) m_pc = st_nxt_pc_i & pd_pkg::ADDR_MASK;
  else if (bu_flush_i) m_pc = bu_nxt_pc_i & pd_pkg::ADDR_MASK;
  else if (!m_stall) m_pc = if_pc_i & pd_pkg::ADDR_MASK;
  if (flush || later_exc_i || (!id_stall_i && m_csr_seq != 2'b00)) m_insn.bubble = 1'b1;
  else if (!id_stall_i) m_insn.bubble = if_insn_i.bubble;
  if (!id_stall_i) m_insn.instr = if_insn_i.instr;
  m_exc = (flush || m_stall) ? '0 : if_exc_i;
  if (!m_stall) begin
    m_tag = m_tag_nxt;
    m_rsb_pc = stack_top();
    m_rsb_pc_ok = 1'b1;
    // Full stack drops its oldest entry
    if (m_push && m_pop && m_stack.size() != 0) begin
      m_stack[0] = ret_pc;
    end else if (m_push) begin
      m_stack.push_front(ret_pc);
      if (m_stack.size() > pd_pkg::RSB_DEPTH) void'(m_stack.pop_back());
    end else if (m_pop && m_stack.size() != 0) begin
      void'(m_stack.pop_front());
    end
  end
  m_stalled_br = m_taken & id_stall_i;
  // Two stall cycles after a CSR write
  if (m_csr_seq[1]) m_csr_seq = 2'b00;
  else if (!id_stall_i)
    m_csr_seq = {m_csr_seq[0],
                 m_csr_seq[0] | (writes_csr(if_insn_i.instr) & !if_insn_i.bubble)};
endfunction

`endif

// ==== testbench/pre_decode_tb.sv ====
`timescale 1ns/1ps

module pre_decode_tb;

  localparam int STALL_LIMIT = 8;

  logic                          clk_i = 1'b0;
  logic                          rst_ni;
  pd_pkg::insn_t                 if_insn_i;
  logic [pd_pkg::XLEN-1:0]       if_pc_i;
  pd_pkg::exc_t                  if_exc_i;
  logic                          id_stall_i;
  logic                          later_exc_i;
  logic                          bu_flush_i;
  logic                          st_flush_i;
  logic [pd_pkg::XLEN-1:0]       bu_nxt_pc_i;
  logic [pd_pkg::XLEN-1:0]       st_nxt_pc_i;
  pd_pkg::insn_t                 pd_insn_o;
  logic [pd_pkg::XLEN-1:0]       pd_pc_o;
  pd_pkg::exc_t                  pd_exc_o;
  pd_pkg::bp_tag_t               pd_tag_o;
  logic [pd_pkg::XLEN-1:0]       pd_rsb_pc_o;
  pd_pkg::reg_addr_t             pd_rs1_o;
  pd_pkg::reg_addr_t             pd_rs2_o;
  logic [pd_pkg::CSR_ADDR_W-1:0] pd_csr_addr_o;
  logic [pd_pkg::XLEN-1:0]       pd_nxt_pc_o;
  logic                          pd_latch_nxt_pc_o;
  logic                          pd_stall_o;
  logic                          pd_flush_o;

  logic [31:0]             rng_state = 32'h7309;
  int                      test_err;
  int                      err_cnt;
  int                      check_cnt;
  int                      test_cnt;
  int                      latch_cnt;
  logic                    stall_seen;
  logic [pd_pkg::XLEN-1:0] nxt_pc_seen;

  `include "pd_ref_model.svh"

  always #5 clk_i = ~clk_i;

  pre_decode_top pre_decode_top_inst (.*);

  // Hard stop if the sequence hangs
  initial begin
    #100000;
    $display("timeout, the test sequence did not finish");
    $display("=== FAIL ===");
    $finish;
  end

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_insn(string name, pd_pkg::insn_t got, pd_pkg::insn_t exp);
    check_cnt++;
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      test_err++;
    end
  endtask

  task automatic check_exc(string name, pd_pkg::exc_t got, pd_pkg::exc_t exp);
    check_cnt++;
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      test_err++;
    end
  endtask

  task automatic check_pc(string name, logic [pd_pkg::XLEN-1:0] got,
                          logic [pd_pkg::XLEN-1:0] exp);
    check_cnt++;
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      test_err++;
    end
  endtask

  task automatic check_tag(string name, pd_pkg::bp_tag_t got, pd_pkg::bp_tag_t exp);
    check_cnt++;
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      test_err++;
    end
  endtask

  task automatic check_reg(string name, pd_pkg::reg_addr_t got, pd_pkg::reg_addr_t exp);
    check_cnt++;
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      test_err++;
    end
  endtask

  task automatic check_csr_addr(string name, logic [pd_pkg::CSR_ADDR_W-1:0] got,
                                logic [pd_pkg::CSR_ADDR_W-1:0] exp);
    check_cnt++;
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      test_err++;
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    check_cnt++;
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      test_err++;
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    // Fold high bits down, low LCG bits repeat fast
    return rng_state ^ (rng_state >> 16);
  endfunction

  // Biased toward link registers
  function automatic pd_pkg::reg_addr_t pick_reg();
    logic [31:0] r;
    r = lcg_next();
    case (r[9:8])
      2'd0: return 5'd1;
      2'd1: return 5'd5;
      default: return r[4:0];
    endcase
  endfunction

  function automatic logic [31:0] make_instr(int kind);
    logic [31:0] w;
    w = lcg_next();
    w[11:7] = pick_reg();
    w[19:15] = pick_reg();
    case (kind)
      0: w[6:0] = pd_pkg::OPC_JAL;
      1: begin
        w[6:0] = pd_pkg::OPC_JALR;
        w[14:12] = 3'b000;
      end
      2: w[6:0] = pd_pkg::OPC_BRANCH;
      3: w[6:0] = pd_pkg::OPC_SYSTEM;
      default: w[6:0] = 7'b001_0011;
    endcase
    return w;
  endfunction

  task automatic drive_idle();
    if_insn_i = '{instr: pd_pkg::INSTR_NOP, bubble: 1'b0};
    if_pc_i = 32'h0000_0100;
    if_exc_i = '0;
    id_stall_i = 1'b0;
    later_exc_i = 1'b0;
    bu_flush_i = 1'b0;
    st_flush_i = 1'b0;
    bu_nxt_pc_i = '0;
    st_nxt_pc_i = '0;
  endtask

  // Mode picks the instruction mix, mode 4 adds flushes
  task automatic drive_random(int mode);
    logic [31:0] r;
    logic [31:0] p;
    int          kind;
    r = lcg_next();
    p = lcg_next();
    case (mode)
      1: kind = r[12] ? 0 : 2;
      2: kind = r[12] ? 0 : 1;
      3: kind = r[12] ? 3 : 4;
      default: kind = r[14:12] % 5;
    endcase
    if_insn_i.instr = make_instr(kind);
    // No return prediction without a stack entry
    if (kind == 1 && m_stack.size() == 0) if_insn_i.instr[19:15] = '0;
    if_insn_i.bubble = (r[17:15] == 3'd0);
    if_pc_i = {p[31:2], 2'b00};
    if_exc_i.illegal = r[2] & r[3];
    if_exc_i.misaligned = r[4] & r[5];
    if_exc_i.fault = r[6] & r[7];
    if_exc_i.any = if_exc_i.illegal | if_exc_i.misaligned | if_exc_i.fault;
    id_stall_i = (r[21:20] == 2'd0);
    later_exc_i = (mode == 4) && (r[23:22] == 2'd0);
    bu_flush_i = (mode == 4) && (r[25:24] == 2'd0);
    st_flush_i = (mode == 4) && (r[27:26] == 2'd0);
    bu_nxt_pc_i = lcg_next();
    st_nxt_pc_i = lcg_next();
  endtask

  // Check at the falling edge, then step the model
  task automatic cycle();
    @(negedge clk_i);
    model_predict();
    check_pc("pd_nxt_pc_o", pd_nxt_pc_o, m_nxt_pc);
    check_bit("pd_latch_nxt_pc_o", pd_latch_nxt_pc_o, m_taken & !m_stalled_br);
    check_bit("pd_stall_o", pd_stall_o, m_stall);
    check_bit("pd_flush_o", pd_flush_o, bu_flush_i | st_flush_i);
    // Early fields straight from the fetch word
    check_reg("pd_rs1_o", pd_rs1_o, if_insn_i.instr[19:15]);
    check_reg("pd_rs2_o", pd_rs2_o, if_insn_i.instr[24:20]);
    check_csr_addr("pd_csr_addr_o", pd_csr_addr_o, if_insn_i.instr[31:20]);
    check_insn("pd_insn_o", pd_insn_o, m_insn);
    check_pc("pd_pc_o", pd_pc_o, m_pc);
    check_exc("pd_exc_o", pd_exc_o, m_exc);
    check_tag("pd_tag_o", pd_tag_o, m_tag);
    if (m_rsb_pc_ok) check_pc("pd_rsb_pc_o", pd_rsb_pc_o, m_rsb_pc);
    latch_cnt += pd_latch_nxt_pc_o;
    stall_seen = pd_stall_o;
    nxt_pc_seen = pd_nxt_pc_o;
    model_advance();
    @(posedge clk_i);
    #1;
  endtask

  task automatic run_random(int mode, int cycles);
    repeat (cycles) begin
      drive_random(mode);
      cycle();
    end
  endtask

  // Idle cycles let a CSR stall run out
  task automatic settle();
    repeat (3) begin
      drive_idle();
      cycle();
    end
  endtask

  task automatic end_test(string name);
    test_cnt++;
    err_cnt += test_err;
    if (test_err == 0) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, test_err);
    test_err = 0;
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    int n;
    rst_ni = 1'b0;
    drive_idle();
    if_insn_i.bubble = 1'b1;
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    model_reset();

    run_random(0, 300);
    end_test("pass-through and hold");

    // Backward beq held by decode, one strobe only
    run_random(1, 200);
    settle();
    if_insn_i = '{instr: 32'hFE00_0FE3, bubble: 1'b0};
    id_stall_i = 1'b1;
    latch_cnt = 0;
    repeat (3) cycle();
    id_stall_i = 1'b0;
    cycle();
    if (latch_cnt != 1) begin
      $display("stalled backward branch strobed %0d times instead of once", latch_cnt);
      test_err++;
    end
    end_test("branch prediction");

    // jal ra then ret
    settle();
    drive_idle();
    if_insn_i.instr = 32'h0100_00EF;
    if_pc_i = 32'h0000_1000;
    cycle();
    drive_idle();
    if_insn_i.instr = 32'h0000_8067;
    if_pc_i = 32'h0000_1010;
    cycle();
    check_pc("pd_nxt_pc_o", nxt_pc_seen, 32'h0000_1004);
    run_random(2, 200);
    end_test("return stack");

    // csrrw x0, 0x300, ra
    settle();
    drive_idle();
    if_insn_i.instr = 32'h3000_9073;
    cycle();
    drive_idle();
    cycle();
    n = 0;
    while (stall_seen && n < STALL_LIMIT) begin
      n++;
      cycle();
    end
    if (n == STALL_LIMIT) begin
      $display("pd_stall_o stayed high after a CSR write");
      test_err++;
    end else if (n != 2) begin
      $display("CSR write stalled the stage %0d cycles instead of two", n);
      test_err++;
    end
    // csrrs t0, 0x300, x0 only reads
    settle();
    drive_idle();
    if_insn_i.instr = 32'h3000_22F3;
    cycle();
    drive_idle();
    cycle();
    if (stall_seen) begin
      $display("CSRRS with rs1 x0 stalled the stage");
      test_err++;
    end
    run_random(3, 200);
    end_test("CSR write stall");

    // Both flushes at once
    settle();
    drive_idle();
    bu_flush_i = 1'b1;
    st_flush_i = 1'b1;
    bu_nxt_pc_i = 32'h0000_4444;
    st_nxt_pc_i = 32'h0000_8883;
    cycle();
    check_pc("pd_pc_o", pd_pc_o, 32'h0000_8880);
    check_bit("pd_insn_o.bubble", pd_insn_o.bubble, 1'b1);
    run_random(4, 300);
    end_test("flushes and exceptions");

    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) $display("=== PASS ===");
    else $display("=== FAIL ===");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+testbench
src/pd_pkg.sv
src/pd_decode_if.sv
src/pd_insn_decode.sv
src/return_stack.sv
src/pd_branch_predict.sv
src/pd_stage_regs.sv
src/pre_decode_top.sv
testbench/pre_decode_tb.sv
